//--- files.f
hdl/mem_bus_pkg.sv
hdl/sram_timing_pkg.sv
hdl/wb_target_decode.sv
hdl/sram_timing_regs.sv
hdl/sram_ctrl.sv
hdl/pet_sram_top.sv
testbench/sram_model.sv
testbench/pet_sram_checker.sv
testbench/tb_pet_sram.sv

//--- hdl/mem_bus_pkg.sv
/*
 * Memory bus definitions
 * Data and address widths shared by the Wishbone bus and the SRAM pins,
 * plus the split of the bus address space into SRAM and register space.
 */

package mem_bus_pkg;

    // Byte wide data on both the bus and the chip
    localparam int DATA_WIDTH = 8;

    // AS6C1008 is 128K deep
    localparam int RAM_ADDR_WIDTH = 17;

    // One extra bus address bit above the SRAM range
    localparam int WB_ADDR_WIDTH = RAM_ADDR_WIDTH + 1;

    // Set selects the timing registers
    // Clear selects the SRAM
    localparam int REG_SPACE_BIT = RAM_ADDR_WIDTH;

    // Register offsets in register space
    // Only bus address bit 0 is decoded there
    localparam logic REG_READ_WAIT  = 1'b0;
    localparam logic REG_WRITE_HOLD = 1'b1;

endpackage

//--- hdl/pet_sram_top.sv
/*
 * PET static RAM subsystem
 * Joins the address decoder, the timing register block and the SRAM
 * controller behind one Wishbone B4 pipelined port. Adds no latency of
 * its own. Stall comes from the SRAM controller alone.
 */
`timescale 1ns/100ps

module pet_sram_top (
    input  logic                                  wb_clock_i,
    input  logic                                  reset_i,

    // Wishbone bus from the master
    input  logic [mem_bus_pkg::WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]    wb_data_i,
    output logic [mem_bus_pkg::DATA_WIDTH-1:0]    wb_data_o,
    input  logic                                  wb_we_i,
    input  logic                                  wb_cycle_i,
    input  logic                                  wb_strobe_i,
    output logic                                  wb_stall_o,
    output logic                                  wb_ack_o,

    // SRAM pins
    output logic [mem_bus_pkg::RAM_ADDR_WIDTH-1:0] ram_addr_o,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]     ram_data_i,
    output logic [mem_bus_pkg::DATA_WIDTH-1:0]     ram_data_o,
    output logic                                   ram_oe_o,
    output logic                                   ram_we_o,
    output logic                                   ram_data_oe_o
);

    logic                                   ram_strobe;
    logic                                   reg_strobe;
    logic                                   ram_ack;
    logic                                   reg_ack;
    logic [mem_bus_pkg::DATA_WIDTH-1:0]     ram_rd_data;
    logic [mem_bus_pkg::DATA_WIDTH-1:0]     reg_rd_data;
    logic [sram_timing_pkg::WAIT_WIDTH-1:0] read_wait;
    logic [sram_timing_pkg::WAIT_WIDTH-1:0] write_hold;

    // Request is taken only while not stalled
    // Keeps a held register request from acking during an SRAM access
    wb_target_decode wb_target_decode_inst (
        .wb_addr_i    (wb_addr_i),
        .wb_cycle_i   (wb_cycle_i),
        .wb_strobe_i  (wb_strobe_i && !wb_stall_o),
        .ram_strobe_o (ram_strobe),
        .reg_strobe_o (reg_strobe),
        .ram_ack_i    (ram_ack),
        .reg_ack_i    (reg_ack),
        .ram_data_i   (ram_rd_data),
        .reg_data_i   (reg_rd_data),
        .wb_ack_o     (wb_ack_o),
        .wb_data_o    (wb_data_o)
    );

    sram_timing_regs sram_timing_regs_inst (
        .wb_clock_i   (wb_clock_i),
        .reset_i      (reset_i),
        .reg_sel_i    (wb_addr_i[0]),
        .wb_data_i    (wb_data_i),
        .wb_we_i      (wb_we_i),
        .wb_strobe_i  (reg_strobe),
        .wb_data_o    (reg_rd_data),
        .wb_ack_o     (reg_ack),
        .read_wait_o  (read_wait),
        .write_hold_o (write_hold)
    );

    // Low address bits index the chip
    sram_ctrl sram_ctrl_inst (
        .wb_clock_i    (wb_clock_i),
        .reset_i       (reset_i),
        .wb_addr_i     (wb_addr_i[mem_bus_pkg::RAM_ADDR_WIDTH-1:0]),
        .wb_data_i     (wb_data_i),
        .wb_data_o     (ram_rd_data),
        .wb_we_i       (wb_we_i),
        .wb_strobe_i   (ram_strobe),
        .wb_stall_o    (wb_stall_o),
        .wb_ack_o      (ram_ack),
        .read_wait_i   (read_wait),
        .write_hold_i  (write_hold),
        .ram_oe_o      (ram_oe_o),
        .ram_we_o      (ram_we_o),
        .ram_data_oe_o (ram_data_oe_o),
        .ram_addr_o    (ram_addr_o),
        .ram_data_i    (ram_data_i),
        .ram_data_o    (ram_data_o)
    );

endmodule

//--- hdl/sram_ctrl.sv
/*
 * SRAM controller
 * Wishbone B4 pipelined peripheral for an asynchronous byte wide SRAM.
 * Each accepted access becomes one OE or WE strobe on the chip pins,
 * held for the read wait or write hold count from the timing registers.
 * Stall stays high from acceptance until the controller is ready again,
 * and a read adds one turnaround cycle so the chip can release the bus.
 */
`timescale 1ns/100ps

module sram_ctrl (
    input  logic                                    wb_clock_i,
    input  logic                                    reset_i,

    // Bus side, strobe already qualified with cycle
    input  logic [mem_bus_pkg::RAM_ADDR_WIDTH-1:0]  wb_addr_i,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]      wb_data_i,
    output logic [mem_bus_pkg::DATA_WIDTH-1:0]      wb_data_o,
    input  logic                                    wb_we_i,
    input  logic                                    wb_strobe_i,
    output logic                                    wb_stall_o,
    output logic                                    wb_ack_o,

    // Strobe lengths in clock cycles
    input  logic [sram_timing_pkg::WAIT_WIDTH-1:0]  read_wait_i,
    input  logic [sram_timing_pkg::WAIT_WIDTH-1:0]  write_hold_i,

    // Chip pins
    output logic                                    ram_oe_o,
    output logic                                    ram_we_o,
    output logic                                    ram_data_oe_o,
    output logic [mem_bus_pkg::RAM_ADDR_WIDTH-1:0]  ram_addr_o,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]      ram_data_i,
    output logic [mem_bus_pkg::DATA_WIDTH-1:0]      ram_data_o
);

    // One-hot states
    typedef enum logic [3:0] {
        READY      = 4'b0001,
        READING    = 4'b0010,
        TURNAROUND = 4'b0100,
        WRITING    = 4'b1000
    } state_t;

    state_t                                state;
    logic [sram_timing_pkg::WAIT_WIDTH-1:0] cycle_count;
    logic                                  accept;
    logic                                  read_done;
    logic                                  write_done;

    // Only idle controller takes a request
    assign accept = wb_strobe_i && (state == READY);

    // Counter holds the number of strobe cycles seen so far
    assign read_done  = (state == READING) && (cycle_count == read_wait_i);
    assign write_done = (state == WRITING) && (cycle_count == write_hold_i);

    // Drive the data pins exactly while writing
    assign ram_data_oe_o = ram_we_o;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            state       <= READY;
            cycle_count <= '0;
            wb_ack_o    <= 1'b0;
            wb_stall_o  <= 1'b0;
            ram_oe_o    <= 1'b0;
            ram_we_o    <= 1'b0;
        end else begin
            // Ack is a single cycle pulse
            wb_ack_o <= 1'b0;

            case (state)
                READY: begin
                    if (accept) begin
                        // First strobe cycle counts as one
                        cycle_count <= sram_timing_pkg::WAIT_MIN;
                        wb_stall_o  <= 1'b1;
                        ram_oe_o    <= !wb_we_i;
                        ram_we_o    <= wb_we_i;
                        state       <= wb_we_i ? WRITING : READING;
                    end
                end
                READING: begin
                    if (read_done) begin
                        // Data latched in the datapath block on this edge
                        wb_ack_o <= 1'b1;
                        ram_oe_o <= 1'b0;
                        state    <= TURNAROUND;
                    end else begin
                        cycle_count <= cycle_count + 1'b1;
                    end
                end
                TURNAROUND: begin
                    // Chip output goes high-Z, then ready again
                    wb_stall_o <= 1'b0;
                    state      <= READY;
                end
                WRITING: begin
                    if (write_done) begin
                        // Data and address have zero hold, release at once
                        wb_ack_o   <= 1'b1;
                        wb_stall_o <= 1'b0;
                        ram_we_o   <= 1'b0;
                        state      <= READY;
                    end else begin
                        cycle_count <= cycle_count + 1'b1;
                    end
                end
                default: begin
                    // Illegal encoding, drop any strobe and recover
                    wb_stall_o <= 1'b0;
                    ram_oe_o   <= 1'b0;
                    ram_we_o   <= 1'b0;
                    state      <= READY;
                end
            endcase
        end
    end

    // Address and data captured at acceptance
    // Held steady on the pins for the whole strobe
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            ram_addr_o <= wb_addr_i;
            ram_data_o <= wb_data_i;
        end
        if (read_done) begin
            wb_data_o <= ram_data_i;
        end
    end

endmodule

//--- hdl/sram_timing_pkg.sv
/*
 * SRAM timing definitions
 * Clock period, conversion of data sheet nanosecond figures into whole
 * clock cycles, and the reset defaults of the controller's wait counts.
 * Figures are for an AS6C1008-55 class part.
 */

package sram_timing_pkg;

    // Wait counts live in 3 bit registers
    localparam int WAIT_WIDTH = 3;

    // 100 MHz system clock
    localparam int CLOCK_PERIOD_NS = 10;

    // Rounds up, a strobe may be longer than asked but never shorter
    function automatic int ns_to_cycles(input int ns);
        int cycles;
        cycles = (ns + CLOCK_PERIOD_NS - 1) / CLOCK_PERIOD_NS;
        return cycles;
    endfunction

    // Address and OE to valid data
    localparam int T_READ_ACCESS_NS = 55;

    // Minimum WE pulse width
    // Address setup and data hold are zero on this part
    localparam int T_WRITE_PULSE_NS = 45;

    // Reset values of the timing registers
    localparam logic [WAIT_WIDTH-1:0] READ_WAIT_DEFAULT =
        WAIT_WIDTH'(ns_to_cycles(T_READ_ACCESS_NS));
    localparam logic [WAIT_WIDTH-1:0] WRITE_HOLD_DEFAULT =
        WAIT_WIDTH'(ns_to_cycles(T_WRITE_PULSE_NS));

    // Shortest legal count
    // A write of zero is stored as this
    localparam logic [WAIT_WIDTH-1:0] WAIT_MIN = 1;

endpackage

//--- hdl/sram_timing_regs.sv
/*
 * SRAM timing registers
 * Wishbone register block with the controller's read wait and write hold
 * counts. Counts reset to values derived from the data sheet and can be
 * rewritten by software for faster or slower parts. Every access acks on
 * the following edge without stalling.
 */
`timescale 1ns/100ps

module sram_timing_regs (
    input  logic                                   wb_clock_i,
    input  logic                                   reset_i,

    // Bus address bit 0 picks the register
    input  logic                                   reg_sel_i,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]     wb_data_i,
    input  logic                                   wb_we_i,
    input  logic                                   wb_strobe_i,
    output logic [mem_bus_pkg::DATA_WIDTH-1:0]     wb_data_o,
    output logic                                   wb_ack_o,

    // Levels into the SRAM controller
    output logic [sram_timing_pkg::WAIT_WIDTH-1:0] read_wait_o,
    output logic [sram_timing_pkg::WAIT_WIDTH-1:0] write_hold_o
);

    logic [sram_timing_pkg::WAIT_WIDTH-1:0] write_value;
    logic [sram_timing_pkg::WAIT_WIDTH-1:0] read_value;

    // Only the low bits are kept
    // Zero would mean no strobe at all, so clamp it
    assign write_value = (wb_data_i[sram_timing_pkg::WAIT_WIDTH-1:0] == '0)
        ? sram_timing_pkg::WAIT_MIN
        : wb_data_i[sram_timing_pkg::WAIT_WIDTH-1:0];

    // Selected register for readback
    assign read_value = (reg_sel_i == mem_bus_pkg::REG_WRITE_HOLD)
        ? write_hold_o
        : read_wait_o;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            wb_ack_o     <= 1'b0;
            read_wait_o  <= sram_timing_pkg::READ_WAIT_DEFAULT;
            write_hold_o <= sram_timing_pkg::WRITE_HOLD_DEFAULT;
        end else begin
            // One ack per accepted strobe
            wb_ack_o <= wb_strobe_i;

            if (wb_strobe_i && wb_we_i) begin
                if (reg_sel_i == mem_bus_pkg::REG_READ_WAIT) begin
                    read_wait_o <= write_value;
                end else begin
                    write_hold_o <= write_value;
                end
            end
        end
    end

    // Readback, count zero-extended to the bus width
    always_ff @(posedge wb_clock_i) begin
        if (wb_strobe_i) begin
            wb_data_o <= {
                {(mem_bus_pkg::DATA_WIDTH - sram_timing_pkg::WAIT_WIDTH){1'b0}},
                read_value
            };
        end
    end

endmodule

//--- hdl/wb_target_decode.sv
/*
 * Wishbone target decoder
 * Routes each bus request either to the SRAM controller or to the timing
 * registers by one address bit, and merges their acks and read data back
 * onto the master's response lines. Purely combinational.
 */
`timescale 1ns/100ps

module wb_target_decode (
    // Request from the master
    input  logic [mem_bus_pkg::WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic                                  wb_cycle_i,
    input  logic                                  wb_strobe_i,

    // Per-target strobes
    output logic                                  ram_strobe_o,
    output logic                                  reg_strobe_o,

    // Per-target responses
    input  logic                                  ram_ack_i,
    input  logic                                  reg_ack_i,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]    ram_data_i,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]    reg_data_i,

    // Merged response to the master
    output logic                                  wb_ack_o,
    output logic [mem_bus_pkg::DATA_WIDTH-1:0]    wb_data_o
);

    logic bus_request;
    logic reg_space;

    // Strobe counts only inside a bus cycle
    assign bus_request = wb_cycle_i && wb_strobe_i;

    // Upper bus address bit splits the map
    assign reg_space = wb_addr_i[mem_bus_pkg::REG_SPACE_BIT];

    assign ram_strobe_o = bus_request && !reg_space;
    assign reg_strobe_o = bus_request && reg_space;

    // One access in flight, so at most one ack at a time
    assign wb_ack_o = ram_ack_i || reg_ack_i;

    // Data follows whichever target is acking
    // SRAM data is the idle default
    always_comb begin
        if (reg_ack_i) begin
            wb_data_o = reg_data_i;
        end else begin
            wb_data_o = ram_data_i;
        end
    end

endmodule

//--- testbench/pet_sram_checker.sv
/*
 * SRAM pin protocol checker
 * Bound into the subsystem top. Watches the chip strobes, the data
 * output enable, the address during a strobe and the bus ack pulse.
 */
`timescale 1ns/100ps

module pet_sram_checker (
    input logic                                   wb_clock_i,
    input logic                                   reset_i,
    input logic                                   ack_i,
    input logic                                   ram_oe_i,
    input logic                                   ram_we_i,
    input logic                                   ram_data_oe_i,
    input logic [mem_bus_pkg::RAM_ADDR_WIDTH-1:0] ram_addr_i
);

    // Polled by the testbench monitor
    int unsigned failure_count = 0;

    // Read and write strobes never overlap
    oe_we_exclusive: assert property (@(posedge wb_clock_i) disable iff (reset_i)
        !(ram_oe_i && ram_we_i))
        else begin
            $error("OE and WE high together");
            failure_count++;
        end

    // Data pins driven exactly while writing
    data_oe_follows_we: assert property (@(posedge wb_clock_i) disable iff (reset_i)
        ram_data_oe_i == ram_we_i)
        else begin
            $error("Data output enable differs from WE");
            failure_count++;
        end

    // Ack is a single cycle pulse
    ack_single_pulse: assert property (@(posedge wb_clock_i) disable iff (reset_i)
        ack_i |=> !ack_i)
        else begin
            $error("Ack high on two consecutive cycles");
            failure_count++;
        end

    // Address held for the whole strobe
    addr_stable_in_strobe: assert property (@(posedge wb_clock_i) disable iff (reset_i)
        (ram_oe_i || ram_we_i) ##1 (ram_oe_i || ram_we_i) |-> $stable(ram_addr_i))
        else begin
            $error("Address moved during a strobe");
            failure_count++;
        end

endmodule

//--- testbench/sram_model.sv
/*
 * Behavioral asynchronous SRAM
 * 128K by 8 array in the manner of an AS6C1008. Reads are combinational
 * while OE is high. A write lands on the trailing edge of WE. Strobes
 * shorter than the data sheet minimum are reported and flagged.
 */
`timescale 1ns/100ps

module sram_model (
    input  logic [mem_bus_pkg::RAM_ADDR_WIDTH-1:0] addr_i,
    input  logic [mem_bus_pkg::DATA_WIDTH-1:0]     data_i,
    output logic [mem_bus_pkg::DATA_WIDTH-1:0]     data_o,
    input  logic                                   oe_i,
    input  logic                                   we_i,
    output logic                                   timing_fault_o
);

    // Storage, one byte per address
    logic [mem_bus_pkg::DATA_WIDTH-1:0] mem [2**mem_bus_pkg::RAM_ADDR_WIDTH];

    // Start of the current strobe, negative when none is open
    realtime oe_rise = -1.0;
    realtime we_rise = -1.0;

    initial begin
        timing_fault_o = 1'b0;
    end

    // Chip drives the bus only while OE is high
    assign data_o = oe_i ? mem[addr_i] : 'x;

    always @(posedge oe_i) begin
        oe_rise = $realtime;
    end

    // Controller samples the data on the edge that drops OE
    always @(negedge oe_i) begin
        if (oe_rise >= 0.0) begin
            if (($realtime - oe_rise) < sram_timing_pkg::T_READ_ACCESS_NS) begin
                $display("SRAM model: read strobe of %0.1f ns is shorter than %0d ns access time",
                         $realtime - oe_rise, sram_timing_pkg::T_READ_ACCESS_NS);
                timing_fault_o = 1'b1;
            end
            oe_rise = -1.0;
        end
    end

    always @(posedge we_i) begin
        we_rise = $realtime;
    end

    // Data latched as WE ends, address and data still held
    always @(negedge we_i) begin
        if (we_rise >= 0.0) begin
            mem[addr_i] = data_i;
            if (($realtime - we_rise) < sram_timing_pkg::T_WRITE_PULSE_NS) begin
                $display("SRAM model: write pulse of %0.1f ns is shorter than %0d ns minimum",
                         $realtime - we_rise, sram_timing_pkg::T_WRITE_PULSE_NS);
                timing_fault_o = 1'b1;
            end
            we_rise = -1.0;
        end
    end

endmodule

//--- testbench/tb_pet_sram.sv
/*
 * Testbench for the PET static RAM subsystem
 * Runs a table of register and SRAM accesses, a register read held
 * behind a busy SRAM read, and random bytes checked against a local copy.
 */
`timescale 1ns/100ps

module tb_pet_sram;

    typedef struct packed {
        logic        is_write;
        logic [17:0] addr;
        logic [7:0]  wdata;
        logic [7:0]  rdata;
        logic [3:0]  latency;
    } stim_row_t;

    localparam int TABLE_LEN   = 18;
    localparam int RANDOM_LEN  = 64;
    localparam int CYCLE_LIMIT = TABLE_LEN * 16 + RANDOM_LEN * 32;

    // Bit 17 set selects register space
    localparam logic [17:0] REG_BASE = 18'h20000;

    // Defaults 6 and 5 from 55 ns and 45 ns rounded up to 10 ns cycles
    // Latency is edges from acceptance to the edge that samples ack
    // SRAM ack rises on the last strobe edge so latency is the count plus one
    localparam stim_row_t STIM [TABLE_LEN] = '{
        '{1'b0, REG_BASE,         8'h00, 8'h06, 4'd1},
        '{1'b0, REG_BASE + 18'd1, 8'h00, 8'h05, 4'd1},
        '{1'b1, 18'h00000,        8'hA5, 8'h00, 4'd6},
        '{1'b1, 18'h1FFFF,        8'h5A, 8'h00, 4'd6},
        '{1'b1, 18'h01234,        8'h3C, 8'h00, 4'd6},
        '{1'b0, 18'h00000,        8'h00, 8'hA5, 4'd7},
        '{1'b0, 18'h1FFFF,        8'h00, 8'h5A, 4'd7},
        '{1'b0, 18'h01234,        8'h00, 8'h3C, 4'd7},
        // Slower part with waits of 7 and 6
        '{1'b1, REG_BASE,         8'h07, 8'h00, 4'd1},
        '{1'b1, REG_BASE + 18'd1, 8'h06, 8'h00, 4'd1},
        '{1'b1, 18'h0AAAA,        8'h96, 8'h00, 4'd7},
        '{1'b0, 18'h0AAAA,        8'h00, 8'h96, 4'd8},
        // Zero clamps to one
        '{1'b1, REG_BASE,         8'h00, 8'h00, 4'd1},
        '{1'b0, REG_BASE,         8'h00, 8'h01, 4'd1},
        // Back to defaults before touching the chip again
        '{1'b1, REG_BASE,         8'h06, 8'h00, 4'd1},
        '{1'b1, REG_BASE + 18'd1, 8'h05, 8'h00, 4'd1},
        '{1'b0, REG_BASE + 18'd1, 8'h00, 8'h05, 4'd1},
        '{1'b0, 18'h01234,        8'h00, 8'h3C, 4'd7}
    };

    logic        wb_clock;
    logic        reset;
    logic [17:0] wb_addr;
    logic [7:0]  wb_data_w;
    logic [7:0]  wb_data_r;
    logic        wb_we;
    logic        wb_cycle;
    logic        wb_strobe;
    logic        wb_stall;
    logic        wb_ack;
    logic [16:0] ram_addr;
    logic [7:0]  ram_data_to_chip;
    logic [7:0]  ram_data_from_chip;
    logic        ram_oe;
    logic        ram_we;
    logic        ram_data_oe;
    logic        timing_fault;

    int unsigned cycle_count   = 0;
    int unsigned ack_seen      = 0;
    int unsigned expected_acks = 0;

    pet_sram_top pet_sram_top_inst (
        .wb_clock_i    (wb_clock),
        .reset_i       (reset),
        .wb_addr_i     (wb_addr),
        .wb_data_i     (wb_data_w),
        .wb_data_o     (wb_data_r),
        .wb_we_i       (wb_we),
        .wb_cycle_i    (wb_cycle),
        .wb_strobe_i   (wb_strobe),
        .wb_stall_o    (wb_stall),
        .wb_ack_o      (wb_ack),
        .ram_addr_o    (ram_addr),
        .ram_data_i    (ram_data_from_chip),
        .ram_data_o    (ram_data_to_chip),
        .ram_oe_o      (ram_oe),
        .ram_we_o      (ram_we),
        .ram_data_oe_o (ram_data_oe)
    );

    sram_model sram_model_inst (
        .addr_i         (ram_addr),
        .data_i         (ram_data_to_chip),
        .data_o         (ram_data_from_chip),
        .oe_i           (ram_oe),
        .we_i           (ram_we),
        .timing_fault_o (timing_fault)
    );

    bind pet_sram_top pet_sram_checker pet_sram_checker_inst (
        .wb_clock_i    (wb_clock_i),
        .reset_i       (reset_i),
        .ack_i         (wb_ack_o),
        .ram_oe_i      (ram_oe_o),
        .ram_we_i      (ram_we_o),
        .ram_data_oe_i (ram_data_oe_o),
        .ram_addr_i    (ram_addr_o)
    );

    initial begin
        wb_clock = 1'b0;
        forever #5 wb_clock = ~wb_clock;
    end

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Presents a request on the current rising edge
    task automatic drive_request(input logic is_write, input logic [17:0] addr,
                                 input logic [7:0] data);
        wb_addr   <= addr;
        wb_data_w <= data;
        wb_we     <= is_write;
        wb_cycle  <= 1'b1;
        wb_strobe <= 1'b1;
        expected_acks++;
    endtask

    // Edges from the accepting edge to ack
    task automatic count_to_ack(output int latency);
        latency = 0;
        do begin
            @(negedge wb_clock);
            latency++;
        end while (!wb_ack);
    endtask

    // Holds the request through stall and drops it on the accepting edge
    task automatic accept_and_ack(output logic [7:0] rdata, output int latency);
        @(negedge wb_clock);
        while (wb_stall) begin
            @(negedge wb_clock);
        end
        @(posedge wb_clock);
        wb_cycle  <= 1'b0;
        wb_strobe <= 1'b0;
        count_to_ack(latency);
        rdata = wb_data_r;
    endtask

    task automatic bus_access(input logic is_write, input logic [17:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata,
                              output int latency);
        @(posedge wb_clock);
        drive_request(is_write, addr, wdata);
        accept_and_ack(rdata, latency);
    endtask

    // SRAM read with a register read presented right behind it
    task automatic check_held_request(input logic [17:0] addr, input logic [7:0] expected);
        logic [7:0] rdata;
        int         latency;
        @(posedge wb_clock);
        drive_request(1'b0, addr, 8'h00);
        @(posedge wb_clock);
        drive_request(1'b0, REG_BASE, 8'h00);
        count_to_ack(latency);
        check_value("read ack latency", latency, 7);
        check_value("wb_data_o", wb_data_r, expected);
        // Turnaround still stalls the held request
        check_value("wb_stall_o", wb_stall, 1);
        accept_and_ack(rdata, latency);
        check_value("held ack latency", latency, 1);
        check_value("wb_data_o", rdata, 6);
    endtask

    // Timeout, ack count and failures from the model and checker
    always @(negedge wb_clock) begin
        cycle_count++;
        if (wb_ack) begin
            ack_seen++;
        end
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles", cycle_count);
            stop_with_failure();
        end else if (timing_fault) begin
            $display("SRAM model saw a strobe shorter than the data sheet minimum");
            stop_with_failure();
        end else if (pet_sram_top_inst.pet_sram_checker_inst.failure_count != 0) begin
            $display("Pin protocol assertion failed");
            stop_with_failure();
        end
    end

    initial begin
        logic [7:0]  rdata;
        int          latency;
        logic [31:0] rng;
        logic [16:0] rand_addr [RANDOM_LEN];
        logic [7:0]  shadow [logic [16:0]];
        reset     <= 1'b1;
        wb_addr   <= '0;
        wb_data_w <= '0;
        wb_we     <= 1'b0;
        wb_cycle  <= 1'b0;
        wb_strobe <= 1'b0;
        repeat (2) @(posedge wb_clock);
        reset <= 1'b0;
        @(negedge wb_clock);
        check_value("wb_ack_o", wb_ack, 0);
        check_value("wb_stall_o", wb_stall, 0);
        check_value("ram_oe_o", ram_oe, 0);
        check_value("ram_we_o", ram_we, 0);
        check_value("ram_data_oe_o", ram_data_oe, 0);

        for (int i = 0; i < TABLE_LEN; i++) begin
            bus_access(STIM[i].is_write, STIM[i].addr, STIM[i].wdata, rdata, latency);
            check_value("ack latency", latency, STIM[i].latency);
            if (!STIM[i].is_write) begin
                check_value("wb_data_o", rdata, STIM[i].rdata);
            end
        end

        check_held_request(18'h01234, 8'h3C);

        // Random bytes all written first and then read back
        rng = 32'd3;
        for (int i = 0; i < RANDOM_LEN; i++) begin
            rng = xorshift32(rng);
            rand_addr[i] = rng[16:0];
            rng = xorshift32(rng);
            shadow[rand_addr[i]] = rng[7:0];
            bus_access(1'b1, {1'b0, rand_addr[i]}, rng[7:0], rdata, latency);
        end
        for (int i = 0; i < RANDOM_LEN; i++) begin
            bus_access(1'b0, {1'b0, rand_addr[i]}, 8'h00, rdata, latency);
            check_value("wb_data_o", rdata, shadow[rand_addr[i]]);
        end

        // Let the monitor count the last ack
        repeat (4) @(negedge wb_clock);
        if (ack_seen != expected_acks) begin
            $display("Error: ack count is 0x%0h, expected 0x%0h", ack_seen, expected_acks);
            stop_with_failure();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
